// ==== filelist.f ====
+incdir+hdl
hdl/zx_pkg.sv
hdl/port_bus_apb.sv
hdl/memory_pager.sv
hdl/soundrive.sv
hdl/sigma_delta_dac.sv
hdl/zx_io_top.sv
test/tb_zx_io_top.sv

// ==== hdl/memory_pager.sv ====
// Memory pager with the 7FFD and 1FFD registers mapping CPU addresses to external memory
`include "zx_defines.svh"

module memory_pager (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::machine_t  machine,
	input  logic              wr_7ffd,
	input  logic              wr_1ffd,
	input  logic [7:0]        wdata,
	input  logic [15:0]       mem_addr,
	input  logic              mem_req,
	input  logic              mem_we,
	output logic              is_plus3,
	output zx_pkg::ext_addr_t ext_addr,
	output logic              ext_req,
	output logic              ext_we,
	output logic [2:0]        screen_bank
);
	zx_pkg::machine_t  machine_q;
	logic [7:0]        page_7ffd;
	logic [7:0]        page_1ffd;
	logic              page_lock;
	logic [1:0]        slot;
	logic [1:0]        rom_page;
	logic [2:0]        ram_bank;
	logic              is_rom;
	zx_pkg::ext_addr_t ext_addr_d;

	assign is_plus3  = (machine_q == zx_pkg::PLUS3);
	assign page_lock = (machine_q == zx_pkg::ZX48) | page_7ffd[5];
	assign slot      = mem_addr[15:14];

	// ====================
	// Paging registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine_q <= machine;    // Machine pin sampled during reset
			page_7ffd <= 8'd0;
			page_1ffd <= 8'd0;
		end else begin
			if (wr_7ffd && !page_lock) begin
				page_7ffd <= wdata;
			end
			if (wr_1ffd && is_plus3 && !page_lock) begin
				page_1ffd <= wdata;
			end
		end
	end

	always_comb begin
		case (machine_q)
			zx_pkg::ZX128: rom_page = {1'b0, page_7ffd[4]};
			zx_pkg::PLUS3: rom_page = {page_1ffd[2], page_7ffd[4]};
			default:       rom_page = 2'd0;
		endcase
	end

	// Slot to bank mapping
	always_comb begin
		is_rom   = 1'b0;
		ram_bank = 3'd0;
		if (page_1ffd[0]) begin
			// +3 all-RAM modes
			case (page_1ffd[2:1])
				2'd0: ram_bank = {1'b0, slot};    // 0-1-2-3
				2'd1: ram_bank = {1'b1, slot};    // 4-5-6-7
				2'd2: ram_bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: begin
					case (slot)
						2'd0: ram_bank = 3'd4;
						2'd1: ram_bank = 3'd7;
						2'd2: ram_bank = 3'd6;
						default: ram_bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (slot)
				2'd0: is_rom = 1'b1;
				2'd1: ram_bank = 3'd5;
				2'd2: ram_bank = 3'd2;
				default: ram_bank = page_7ffd[2:0];
			endcase
		end
	end

	assign ext_addr_d = is_rom ?
		{`ZX_REGION_ROM, 2'b00, rom_page, mem_addr[13:0]} :
		{`ZX_REGION_RAM, 1'b0, ram_bank, mem_addr[13:0]};

	// ====================
	// Request stage
	// ====================
	always_ff @(posedge clk_sys) begin
		ext_addr <= ext_addr_d;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ext_req <= 1'b0;
			ext_we  <= 1'b0;
		end else begin
			ext_req <= mem_req;
			ext_we  <= mem_we & !is_rom;    // ROM is read only
		end
	end

	assign screen_bank = page_7ffd[3] ? `ZX_SCREEN_SHADOW : `ZX_SCREEN_NORMAL;

	// CPU write into slot 0 outside the all-RAM modes lands in ROM and stays a read
	a_no_rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_we && !page_1ffd[0] && slot == 2'd0) |=>
			((ext_addr[`ZX_EXT_ADDR_W-1] == `ZX_REGION_ROM) && !ext_we))
		else $error("External write issued to the ROM region");

endmodule

// ==== hdl/port_bus_apb.sv ====
// APB slave for the Z80 I/O ports with port decoding, the ULA port register and read data
`include "zx_defines.svh"

module port_bus_apb (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [15:0] paddr,
	input  logic [7:0]  pwdata,
	output logic [7:0]  prdata,
	input  logic        tape_in,
	input  logic        is_plus3,
	output logic        wr_7ffd,
	output logic        wr_1ffd,
	output logic        wr_sd_l0,
	output logic        wr_sd_l1,
	output logic        wr_sd_r0,
	output logic        wr_sd_r1,
	output logic [7:0]  wdata,
	output logic [2:0]  border,
	output logic        ear,
	output logic        mic
);
	localparam logic [7:0]  port_ula  = `ZX_PORT_ULA;
	localparam logic [15:0] port_7ffd = `ZX_PORT_7FFD;
	localparam logic [15:0] port_1ffd = `ZX_PORT_1FFD;

	logic io_wr;
	logic sel_ula;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_covox;
	logic sel_sd_a;
	logic sel_sd_b;
	logic sel_sd_c;
	logic sel_sd_d;

	// ====================
	// Port decode
	// ====================
	assign io_wr = psel & penable & pwrite;    // Access phase only

	assign sel_ula  = (paddr[0] == port_ula[0]);
	// On the +3 A14 must be high too, so 1FFD does not alias here
	assign sel_7ffd = (paddr[15] == port_7ffd[15]) && (paddr[1] == port_7ffd[1]) &&
		(!is_plus3 || (paddr[14] == port_7ffd[14]));
	assign sel_1ffd = is_plus3 && (paddr[15:12] == port_1ffd[15:12]) &&
		(paddr[1] == port_1ffd[1]);

	assign sel_covox = (paddr[7:0] == `ZX_PORT_COVOX);
	assign sel_sd_a  = (paddr[7:0] == `ZX_PORT_SD_A);
	assign sel_sd_b  = (paddr[7:0] == `ZX_PORT_SD_B);
	assign sel_sd_c  = (paddr[7:0] == `ZX_PORT_SD_C);
	assign sel_sd_d  = (paddr[7:0] == `ZX_PORT_SD_D);

	// Write strobes, one cycle wide
	assign wr_7ffd  = io_wr & sel_7ffd;
	assign wr_1ffd  = io_wr & sel_1ffd;
	assign wr_sd_l0 = io_wr & (sel_covox | sel_sd_a);
	assign wr_sd_l1 = io_wr & (sel_covox | sel_sd_b);
	assign wr_sd_r0 = io_wr & (sel_covox | sel_sd_c);
	assign wr_sd_r1 = io_wr & (sel_covox | sel_sd_d);
	assign wdata    = pwdata;

	// ====================
	// ULA port FE
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (io_wr && sel_ula) begin
			border <= pwdata[2:0];
			ear    <= pwdata[4];
			mic    <= pwdata[3];
		end
	end

	// Keyboard lines float high here
	assign prdata = sel_ula ? {1'b1, tape_in, 1'b1, 5'b11111} : 8'hFF;

	// Master never raises penable outside a selected transfer
	a_penable_with_psel: assert property (@(posedge clk_sys) disable iff (reset)
		penable |-> psel)
		else $error("APB penable high without psel");

endmodule

// ==== hdl/sigma_delta_dac.sv ====
// First-order sigma-delta modulator turning a PCM sample into a one-bit stream
`include "zx_defines.svh"

module sigma_delta_dac #(
	parameter int width = `ZX_PCM_W
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic [width-1:0] sample,
	output logic             bit_out
);
	// One extra bit holds the carry
	logic [width:0] acc;

	// ====================
	// Accumulator
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
		end else begin
			// Carry is dropped back out on every add
			acc <= {1'b0, acc[width-1:0]} + {1'b0, sample};
		end
	end

	// Density of ones tracks sample / 2**width
	assign bit_out = acc[width];

endmodule

// ==== hdl/soundrive.sv ====
// Covox/SounDrive sample registers mixed with EAR and MIC into left and right PCM
`include "zx_defines.svh"

module soundrive (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         wr_sd_l0,
	input  logic         wr_sd_l1,
	input  logic         wr_sd_r0,
	input  logic         wr_sd_r1,
	input  logic [7:0]   wdata,
	input  logic         ear,
	input  logic         mic,
	output zx_pkg::pcm_t pcm_l,
	output zx_pkg::pcm_t pcm_r
);
	localparam zx_pkg::pcm_t ear_weight = zx_pkg::pcm_t'(`ZX_EAR_WEIGHT);
	localparam zx_pkg::pcm_t mic_weight = zx_pkg::pcm_t'(`ZX_MIC_WEIGHT);

	logic [7:0]   sd_l0;
	logic [7:0]   sd_l1;
	logic [7:0]   sd_r0;
	logic [7:0]   sd_r1;
	zx_pkg::pcm_t beeper;

	// Same beeper level goes to both channels
	assign beeper = (ear ? ear_weight : '0) + (mic ? mic_weight : '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_l0 <= 8'd0;
			sd_l1 <= 8'd0;
			sd_r0 <= 8'd0;
			sd_r1 <= 8'd0;
			pcm_l <= '0;
			pcm_r <= '0;
		end else begin
			if (wr_sd_l0) sd_l0 <= wdata;
			if (wr_sd_l1) sd_l1 <= wdata;
			if (wr_sd_r0) sd_r0 <= wdata;
			if (wr_sd_r1) sd_r1 <= wdata;
			// Peak is 830, fits in 10 bits
			pcm_l <= zx_pkg::pcm_t'(sd_l0) + zx_pkg::pcm_t'(sd_l1) + beeper;
			pcm_r <= zx_pkg::pcm_t'(sd_r0) + zx_pkg::pcm_t'(sd_r1) + beeper;
		end
	end

endmodule

// ==== hdl/zx_defines.svh ====
// Port numbers, field widths, mix weights and region codes for the Spectrum I/O block
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// ====================
// I/O ports
// ====================
`define ZX_PORT_ULA   8'hFE    // Decoded on A0 low only
`define ZX_PORT_7FFD  16'h7FFD
`define ZX_PORT_1FFD  16'h1FFD
`define ZX_PORT_COVOX 8'hFB    // Writes all four SounDrive registers
`define ZX_PORT_SD_A  8'h0F
`define ZX_PORT_SD_B  8'h1F
`define ZX_PORT_SD_C  8'h4F
`define ZX_PORT_SD_D  8'h5F

// ====================
// Widths and weights
// ====================
`define ZX_PCM_W      10
`define ZX_EXT_ADDR_W 19
`define ZX_EAR_WEIGHT 256
`define ZX_MIC_WEIGHT 64

// Value of ext_addr bit 18
`define ZX_REGION_ROM 1'b1
`define ZX_REGION_RAM 1'b0

// Screen banks selected by 7FFD bit 3
`define ZX_SCREEN_NORMAL 3'd5
`define ZX_SCREEN_SHADOW 3'd7

`endif

// ==== hdl/zx_io_top.sv ====
// Spectrum CPU I/O side with the APB port bus, memory pager, sound mixer and two DACs
`include "zx_defines.svh"

module zx_io_top (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [15:0]       paddr,
	input  logic [7:0]        pwdata,
	output logic [7:0]        prdata,
	input  logic [15:0]       mem_addr,
	input  logic              mem_req,
	input  logic              mem_we,
	output zx_pkg::ext_addr_t ext_addr,
	output logic              ext_req,
	output logic              ext_we,
	input  zx_pkg::machine_t  machine,
	input  logic              tape_in,
	output logic [2:0]        border,
	output logic [2:0]        screen_bank,
	output zx_pkg::pcm_t      audio_l_pcm,
	output zx_pkg::pcm_t      audio_r_pcm,
	output logic              audio_l,
	output logic              audio_r
);
	logic       is_plus3;
	logic       wr_7ffd;
	logic       wr_1ffd;
	logic       wr_sd_l0;
	logic       wr_sd_l1;
	logic       wr_sd_r0;
	logic       wr_sd_r1;
	logic [7:0] wdata;
	logic       ear;
	logic       mic;

	// ====================
	// Port decoding
	// ====================
	port_bus_apb port_bus_apb_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.tape_in  (tape_in),
		.is_plus3 (is_plus3),
		.wr_7ffd  (wr_7ffd),
		.wr_1ffd  (wr_1ffd),
		.wr_sd_l0 (wr_sd_l0),
		.wr_sd_l1 (wr_sd_l1),
		.wr_sd_r0 (wr_sd_r0),
		.wr_sd_r1 (wr_sd_r1),
		.wdata    (wdata),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	// ====================
	// Memory
	// ====================
	memory_pager memory_pager_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.machine     (machine),
		.wr_7ffd     (wr_7ffd),
		.wr_1ffd     (wr_1ffd),
		.wdata       (wdata),
		.mem_addr    (mem_addr),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.is_plus3    (is_plus3),
		.ext_addr    (ext_addr),
		.ext_req     (ext_req),
		.ext_we      (ext_we),
		.screen_bank (screen_bank)
	);

	// ====================
	// Audio
	// ====================
	soundrive soundrive_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wr_sd_l0 (wr_sd_l0),
		.wr_sd_l1 (wr_sd_l1),
		.wr_sd_r0 (wr_sd_r0),
		.wr_sd_r1 (wr_sd_r1),
		.wdata    (wdata),
		.ear      (ear),
		.mic      (mic),
		.pcm_l    (audio_l_pcm),
		.pcm_r    (audio_r_pcm)
	);

	sigma_delta_dac #(.width(`ZX_PCM_W)) dac_l_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (audio_l_pcm),
		.bit_out (audio_l)
	);

	sigma_delta_dac #(.width(`ZX_PCM_W)) dac_r_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (audio_r_pcm),
		.bit_out (audio_r)
	);

endmodule

// ==== hdl/zx_pkg.sv ====
// Machine type, external address and PCM sample types for the Spectrum I/O block
`include "zx_defines.svh"

package zx_pkg;

	// Machine type, latched while reset is high
	typedef enum logic [1:0] {
		ZX48  = 2'd0,
		ZX128 = 2'd1,
		PLUS3 = 2'd2
	} machine_t;

	// External memory address
	// Bit 18 set means ROM with the page in bits 15:14
	// Bit 18 clear means RAM with the bank in bits 16:14
	typedef logic [`ZX_EXT_ADDR_W-1:0] ext_addr_t;

	typedef logic [`ZX_PCM_W-1:0] pcm_t;    // Unsigned sample

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds the I/O block testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_zx_io_top -f filelist.f -o tb_zx_io_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_zx_io_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Simulation did not report success"
exit 1

// ==== test/tb_zx_io_top.sv ====
// Trace-driven testbench for the Spectrum I/O block covering APB ports, paging and audio
`include "zx_defines.svh"

module tb_zx_io_top;
	timeunit 1ns;
	timeprecision 100ps;

	logic              clk_sys;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [15:0]       paddr;
	logic [7:0]        pwdata;
	logic [7:0]        prdata;
	logic [15:0]       mem_addr;
	logic              mem_req;
	logic              mem_we;
	zx_pkg::ext_addr_t ext_addr;
	logic              ext_req;
	logic              ext_we;
	zx_pkg::machine_t  machine;
	logic              tape_in;
	logic [2:0]        border;
	logic [2:0]        screen_bank;
	zx_pkg::pcm_t      audio_l_pcm;
	zx_pkg::pcm_t      audio_r_pcm;
	logic              audio_l;
	logic              audio_r;

	int trace_fd;
	int line_total;
	int test_num;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;

	// Right channel state as the SounDrive rules give it
	logic [7:0] model_r0;
	logic [7:0] model_r1;
	logic       model_ear;
	logic       model_mic;

	zx_io_top zx_io_top_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.mem_addr    (mem_addr),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.ext_addr    (ext_addr),
		.ext_req     (ext_req),
		.ext_we      (ext_we),
		.machine     (machine),
		.tape_in     (tape_in),
		.border      (border),
		.screen_bank (screen_bank),
		.audio_l_pcm (audio_l_pcm),
		.audio_r_pcm (audio_r_pcm),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	always #50 clk_sys = ~clk_sys;    // 100 ns period

	// ====================
	// Checks and trace parsing
	// ====================
	task automatic check_value(input string name, input int expected, input int actual,
		input int tol);
		int diff;
		diff = actual - expected;
		test_checks++;
		total_checks++;
		if (diff > tol || diff < -tol) begin
			$display("Fail at %0d ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic end_test();
		if (test_num != 0) begin
			if (test_errors == 0)
				$display("Test %0d passed, %0d checks", test_num, test_checks);
			else
				$display("Test %0d failed, %0d of %0d checks wrong", test_num,
					test_errors, test_checks);
		end
		test_checks = 0;
		test_errors = 0;
	endtask

	// Newline count sizes the watchdog
	task automatic count_lines();
		int fd;
		int ch;
		fd = $fopen("test/zx_io_trace.txt", "r");
		line_total = 1;
		if (fd != 0) begin
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == 10)
					line_total++;
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	// Skips blanks and # comments up to the next op letter
	task automatic next_op(output logic [7:0] op, output logic eof);
		int ch;
		logic [7:0] c;
		logic found;
		found = 1'b0;
		op = 8'd0;
		ch = $fgetc(trace_fd);
		while (ch != -1 && !found) begin
			c = ch[7:0];
			if (c == "#") begin
				while (ch != -1 && ch != 10)
					ch = $fgetc(trace_fd);
			end else if (c != " " && c != "\t" && c != "\n" && c != "\r") begin
				op = c;
				found = 1'b1;
			end
			if (!found && ch != -1)
				ch = $fgetc(trace_fd);
		end
		eof = !found;
	endtask

	task automatic read_hex(output int value);
		int got;
		value = 0;
		got = $fscanf(trace_fd, "%h", value);
		if (got != 1) begin
			$display("Trace file has a missing or unreadable field");
			total_errors++;
		end
	endtask

	// Covox loads both right registers, FE carries EAR in bit 4 and MIC in bit 3
	task automatic track_right_channel(input logic [15:0] addr, input logic [7:0] data);
		if (addr[7:0] == `ZX_PORT_SD_C || addr[7:0] == `ZX_PORT_COVOX)
			model_r0 = data;
		if (addr[7:0] == `ZX_PORT_SD_D || addr[7:0] == `ZX_PORT_COVOX)
			model_r1 = data;
		if (!addr[0]) begin
			model_ear = data[4];
			model_mic = data[3];
		end
	endtask

	function automatic int right_pcm_expected();
		return int'(model_r0) + int'(model_r1) + (model_ear ? `ZX_EAR_WEIGHT : 0) +
			(model_mic ? `ZX_MIC_WEIGHT : 0);
	endfunction

	// ====================
	// Drivers, all starting on a falling edge
	// ====================
	task automatic apply_reset(input int mach, input int tape);
		machine = zx_pkg::machine_t'(mach[1:0]);
		tape_in = tape[0];
		reset = 1'b1;
		model_r0 = 8'd0;
		model_r1 = 8'd0;
		model_ear = 1'b0;
		model_mic = 1'b0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [7:0] data);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk_sys);
		penable = 1'b1;    // Write lands on the next rising edge
		@(negedge clk_sys);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		track_right_channel(addr, data);
	endtask

	task automatic apb_read(input logic [15:0] addr, input int expected);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk_sys);
		penable = 1'b1;
		@(posedge clk_sys);
		check_value("prdata", expected, int'(prdata), 0);
		@(negedge clk_sys);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic we, input int exp_addr,
		input int exp_we);
		mem_addr = addr;
		mem_req = 1'b1;
		mem_we = we;
		@(negedge clk_sys);    // One cycle of latency
		check_value("ext_req", 1, int'(ext_req), 0);
		check_value("ext_addr", exp_addr, int'(ext_addr), 0);
		check_value("ext_we", exp_we, int'(ext_we), 0);
		mem_req = 1'b0;
		mem_we = 1'b0;
	endtask

	task automatic dac_density(input int expected);
		int ones;
		int ones_r;
		ones = 0;
		ones_r = 0;
		repeat (4) @(negedge clk_sys);    // Let the sample settle
		repeat (1024) begin
			@(negedge clk_sys);
			ones = ones + int'(audio_l);
			ones_r = ones_r + int'(audio_r);
		end
		check_value("audio_l ones", expected, ones, 1);
		check_value("audio_r ones", right_pcm_expected(), ones_r, 1);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		logic [7:0] op;
		logic eof;
		int f1;
		int f2;
		int f3;
		int f4;
		clk_sys = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 16'd0;
		pwdata = 8'd0;
		mem_addr = 16'd0;
		mem_req = 1'b0;
		mem_we = 1'b0;
		machine = zx_pkg::ZX128;
		tape_in = 1'b0;
		model_r0 = 8'd0;
		model_r1 = 8'd0;
		model_ear = 1'b0;
		model_mic = 1'b0;
		test_num = 0;
		test_checks = 0;
		test_errors = 0;
		total_checks = 0;
		total_errors = 0;
		count_lines();
		trace_fd = $fopen("test/zx_io_trace.txt", "r");
		if (trace_fd == 0) begin
			$display("Could not open the trace file test/zx_io_trace.txt");
			total_errors++;
		end else begin
			@(negedge clk_sys);
			next_op(op, eof);
			while (!eof) begin
				case (op)
					"T": begin
						end_test();
						read_hex(test_num);
					end
					"R": begin
						read_hex(f1);
						read_hex(f2);
						apply_reset(f1, f2);
					end
					"W": begin
						read_hex(f1);
						read_hex(f2);
						apb_write(f1[15:0], f2[7:0]);
					end
					"D": begin
						read_hex(f1);
						read_hex(f2);
						apb_read(f1[15:0], f2);
					end
					"M": begin
						read_hex(f1);
						read_hex(f2);
						read_hex(f3);
						read_hex(f4);
						mem_access(f1[15:0], f2[0], f3, f4);
					end
					"S": begin
						read_hex(f1);
						read_hex(f2);
						check_value("border", f1, int'(border), 0);
						check_value("screen_bank", f2, int'(screen_bank), 0);
					end
					"P": begin
						read_hex(f1);
						read_hex(f2);
						@(negedge clk_sys);    // Second edge, the registered mix
						check_value("audio_l_pcm", f1, int'(audio_l_pcm), 0);
						check_value("audio_r_pcm", f2, int'(audio_r_pcm), 0);
					end
					"N": begin
						read_hex(f1);
						dac_density(f1);
					end
					default: begin
						$display("Unknown operation '%c' in the trace file", op);
						total_errors++;
					end
				endcase
				next_op(op, eof);
			end
			$fclose(trace_fd);
			end_test();
		end
		$display("Summary: %0d checks, %0d failed", total_checks, total_errors);
		if (total_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog scaled by trace length
	initial begin
		wait (line_total > 0);
		repeat (line_total * 2000) @(posedge clk_sys);
		$display("Run timed out after %0d cycles before the trace finished", line_total * 2000);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== test/zx_io_trace.txt ====
# Ops, fields in hex: T test | R machine tape_in | W paddr pwdata | D paddr prdata
# M mem_addr mem_we ext_addr ext_we | S border screen_bank | P pcm_l pcm_r | N dac_ones
T 1
R 1 0
W 00FE 05
S 5 5
D 00FE BF
D 00FF FF
D 7FFD FF    # odd address misses the ULA
R 1 1
D 00FE FF
T 2
W 7FFD 1B    # bank 3, shadow screen, ROM 1
S 0 7
M C123 1 0C123 1
M 0100 1 44100 0    # ROM write blocked
M 4010 0 14010 0
M 8010 1 08010 1
W 7FFD 26    # bank 6 and lock
M C000 0 18000 0
W 7FFD 0F    # ignored while locked
M C000 0 18000 0
M 0000 0 40000 0
S 0 5
T 3
R 0 0
W 7FFD 1F    # ignored on 48K
S 0 5
M C001 0 00001 0
M 0001 0 40001 0
T 4
R 2 0
W 1FFD 09    # banks 0-1-2-3
S 0 5
M 0005 1 00005 1
M 4005 1 04005 1
M 8005 1 08005 1
M C005 1 0C005 1
W 1FFD 0B    # banks 4-5-6-7
M 0005 1 10005 1
M 4005 1 14005 1
M 8005 1 18005 1
M C005 1 1C005 1
W 1FFD 0D    # banks 4-5-6-3
M 0005 1 10005 1
M 4005 1 14005 1
M 8005 1 18005 1
M C005 1 0C005 1
W 1FFD 0F    # banks 4-7-6-3
M 0005 1 10005 1
M 4005 1 1C005 1
M 8005 1 18005 1
M C005 1 0C005 1
W 1FFD 04    # normal mode, ROM high bit
W 7FFD 10
M 0005 0 4C005 0
T 5
R 1 0
P 000 000
W 000F 10
W 001F 20
W 004F 30
W 005F 40
P 030 070
W 00FE 18    # EAR and MIC
P 170 1B0
W 00FB FF    # Covox
P 33E 33E
W 00FE 10
P 2FE 2FE
T 6
W 00FE 00
N 1FE
W 000F 00
N 0FF
W 00FB 00
N 000
W 00FB FF
W 00FE 18
N 33E
